//--- verilog/sysbus_pkg.sv
// system bus package with request/response types, region map and config block constants
package sysbus_pkg;

  //------------------------------------------------------------
  // region map, address bits 29:20 pick a 1 MB region

  localparam int SYS_REGIONS  = 8;                   // regions handled by the decoder
  localparam int USED_REGIONS = 6;                   // regions with an external block

  localparam logic [9:0] SYSCONF_REGION = 10'h3ff;   // config block sits at the top

  // config block contents, id is class in the top bits, version below
  localparam logic [31:0] SYSCONF_ID      = 32'hfff00001;
  localparam logic [19:0] SYSCONF_ID_OFS  = 20'hf0000;  // id word
  localparam logic [19:0] SYSCONF_CNT_OFS = 20'hf0004;  // region count word

  //------------------------------------------------------------
  // bus payloads

  typedef struct packed {
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;  // write data
    logic [3:0]  sel;    // write byte select
    logic        wen;    // write strobe
    logic        ren;    // read strobe
  } sysbus_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // read data
    logic        err;    // error flag
    logic        ack;    // acknowledge
  } sysbus_resp_t;

  typedef logic [SYS_REGIONS-1:0]  region_mask_t;  // one-hot region select
  typedef logic [USED_REGIONS-1:0] used_mask_t;    // per-block strobes

  // one response per externally served region
  typedef sysbus_resp_t [USED_REGIONS-1:0] region_resp_t;

endpackage

//--- verilog/dac_pkg.sv
// DAC path package with sample, sum and channel pair types plus saturation limits
package dac_pkg;

  //------------------------------------------------------------
  // sample widths

  localparam int DAC_W = 14;  // DAC converter width

  typedef logic signed [DAC_W-1:0] dac_sample_t;  // two's complement sample
  typedef logic signed [DAC_W:0]   dac_sum_t;     // one guard bit for the add

  //------------------------------------------------------------
  // saturation limits

  localparam dac_sample_t DAC_MAX = 14'h1FFF;  // most positive code
  localparam dac_sample_t DAC_MIN = 14'h2000;  // most negative code

  // both output channels together
  typedef struct packed {
    dac_sample_t a;  // channel 1
    dac_sample_t b;  // channel 2
  } dac_pair_t;

endpackage

//--- verilog/sysbus_region_decode.sv
// system bus region decoder, one-hot region select and gated write/read strobes
module sysbus_region_decode (
  input  sysbus_pkg::sysbus_req_t  sys_req_i,      // master request
  output sysbus_pkg::region_mask_t region_sel_o,   // one-hot select, all regions
  output logic                     sysconf_sel_o,  // config block select
  output sysbus_pkg::used_mask_t   region_wen_o,   // write strobe per block
  output sysbus_pkg::used_mask_t   region_ren_o    // read strobe per block
);

  import sysbus_pkg::*;

  logic [9:0] region_idx;  // 1 MB region number

  assign region_idx = sys_req_i.addr[29:20];

  //------------------------------------------------------------
  // region select

  always_comb begin
    for (int r = 0; r < SYS_REGIONS; r++) begin
      region_sel_o[r] = (region_idx == 10'(r));  // only 0..7 ever hit
    end
  end

  // config block decoded apart, it has no strobes of its own
  assign sysconf_sel_o = (region_idx == SYSCONF_REGION);

  //------------------------------------------------------------
  // strobe gating, external blocks only

  assign region_wen_o = region_sel_o[USED_REGIONS-1:0]
                      & {USED_REGIONS{sys_req_i.wen}};  // write into selected block
  assign region_ren_o = region_sel_o[USED_REGIONS-1:0]
                      & {USED_REGIONS{sys_req_i.ren}};  // read from selected block

endmodule

//--- verilog/sysbus_read_mux.sv
// system bus return path that merges block responses, free regions and the config block
module sysbus_read_mux (
  input  sysbus_pkg::sysbus_req_t  sys_req_i,      // only the offset is looked at
  input  sysbus_pkg::region_mask_t region_sel_i,   // one-hot region select
  input  logic                     sysconf_sel_i,  // config block select
  input  sysbus_pkg::region_resp_t region_resp_i,  // responses of the external blocks
  output sysbus_pkg::sysbus_resp_t sys_resp_o      // merged response to the master
);

  import sysbus_pkg::*;

  sysbus_resp_t [SYS_REGIONS-1:0]    all_resp;   // used + free regions
  logic [31:0][SYS_REGIONS-1:0]      rdata_col;  // bit-major read data
  logic [SYS_REGIONS-1:0]            ack_col;    // ack per region
  logic [SYS_REGIONS-1:0]            err_col;    // err per region
  logic [19:0]                       offset;     // offset inside the region
  logic [31:0]                       conf_rdata; // config block word

  assign offset = sys_req_i.addr[19:0];

  //------------------------------------------------------------
  // region responses with the free regions answering at once

  always_comb begin
    for (int r = 0; r < SYS_REGIONS; r++) begin
      if (r < USED_REGIONS) begin
        all_resp[r] = region_resp_i[r];  // external block
      end else begin
        all_resp[r].rdata = '0;  // nothing behind it
        all_resp[r].err   = 1'b0;
        all_resp[r].ack   = 1'b1;  // keep the master from stalling
      end
    end
  end

  // transpose so each data bit lines up with the select vector
  always_comb begin
    for (int r = 0; r < SYS_REGIONS; r++) begin
      for (int b = 0; b < 32; b++) begin
        rdata_col[b][r] = all_resp[r].rdata[b];
      end
      ack_col[r] = all_resp[r].ack;
      err_col[r] = all_resp[r].err;
    end
  end

  //------------------------------------------------------------
  // config block lookup of the fixed words read by the driver

  always_comb begin
    case (offset)
      SYSCONF_ID_OFS:  conf_rdata = SYSCONF_ID;        // device id
      SYSCONF_CNT_OFS: conf_rdata = 32'(SYS_REGIONS);  // region count
      default:         conf_rdata = '0;
    endcase
  end

  //------------------------------------------------------------
  // merge as an AND-OR over the selects

  always_comb begin
    for (int b = 0; b < 32; b++) begin
      sys_resp_o.rdata[b] = |(region_sel_i & rdata_col[b])
                          | (sysconf_sel_i & conf_rdata[b]);
    end
    sys_resp_o.ack = |(region_sel_i & ack_col) | sysconf_sel_i;  // config block always acks
    sys_resp_o.err = |(region_sel_i & err_col);                  // config block never errs
  end

  // out-of-range regions select nothing and return all zero with ack low

endmodule

//--- verilog/dac_sat_sum.sv
// one DAC channel, signed add of generator and controller samples with registered saturation
module dac_sat_sum (
  input  logic                 adc_clk,  // ADC data clock
  input  logic                 rst_n_i,  // sync reset, active low
  input  dac_pkg::dac_sample_t asg_i,    // generator sample
  input  dac_pkg::dac_sample_t pid_i,    // controller sample
  output dac_pkg::dac_sample_t dac_o     // saturated sum, one cycle late
);

  import dac_pkg::*;

  dac_sum_t    sum;  // sign-extended sum
  dac_sample_t sat;  // clamped value

  assign sum = dac_sum_t'(asg_i) + dac_sum_t'(pid_i);

  //------------------------------------------------------------
  // saturation on the two top bits of the sum

  always_comb begin
    case (sum[DAC_W:DAC_W-1])
      2'b01:   sat = DAC_MAX;          // pos. overflow
      2'b10:   sat = DAC_MIN;          // neg. overflow
      default: sat = sum[DAC_W-1:0];   // fits, drop guard bit
    endcase
  end

  //------------------------------------------------------------
  // output register

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_o <= '0;  // mid-scale
    end else begin
      dac_o <= sat;
    end
  end

endmodule

//--- verilog/rp_fabric_top.sv
// fabric top level joining the system bus decoder, the read mux and the two DAC mixers
module rp_fabric_top (
  input  logic                     adc_clk,        // ADC data clock
  input  logic                     rst_n_i,        // sync reset, active low

  //------------------------------------------------------------
  // system bus

  input  sysbus_pkg::sysbus_req_t  sys_req_i,      // master request
  output sysbus_pkg::sysbus_resp_t sys_resp_o,     // merged response
  output sysbus_pkg::used_mask_t   region_wen_o,   // write strobes to blocks
  output sysbus_pkg::used_mask_t   region_ren_o,   // read strobes to blocks
  input  sysbus_pkg::region_resp_t region_resp_i,  // block responses

  //------------------------------------------------------------
  // DAC path

  input  dac_pkg::dac_pair_t       asg_i,          // generator samples
  input  dac_pkg::dac_pair_t       pid_i,          // controller samples
  output dac_pkg::dac_pair_t       dac_o           // mixed samples to the DAC
);

  import sysbus_pkg::*;
  import dac_pkg::*;

  region_mask_t region_sel;   // one-hot region select
  logic         sysconf_sel;  // config block select
  dac_sample_t  dac_a;        // channel 1 result
  dac_sample_t  dac_b;        // channel 2 result

  //------------------------------------------------------------
  // system bus decode and return path

  sysbus_region_decode i_decode (
    .sys_req_i     (sys_req_i),     // master request
    .region_sel_o  (region_sel),    // to read mux
    .sysconf_sel_o (sysconf_sel),   // to read mux
    .region_wen_o  (region_wen_o),  // write strobes out
    .region_ren_o  (region_ren_o)   // read strobes out
  );

  sysbus_read_mux i_read_mux (
    .sys_req_i     (sys_req_i),      // offset for config lookup
    .region_sel_i  (region_sel),
    .sysconf_sel_i (sysconf_sel),
    .region_resp_i (region_resp_i),  // block responses
    .sys_resp_o    (sys_resp_o)      // back to master
  );

  //------------------------------------------------------------
  // ASG + PID sum with saturation, one instance per channel

  dac_sat_sum i_dac_a (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .asg_i   (asg_i.a),  // CH 1
    .pid_i   (pid_i.a),
    .dac_o   (dac_a)
  );

  dac_sat_sum i_dac_b (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .asg_i   (asg_i.b),  // CH 2
    .pid_i   (pid_i.b),
    .dac_o   (dac_b)
  );

  // repack the channel results
  assign dac_o = '{a: dac_a, b: dac_b};

endmodule

//--- verification/rp_fabric_tb.sv
// testbench for the fabric top, checks bus decode, bus return path and DAC mixing against reference models
module rp_fabric_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import sysbus_pkg::*;
  import dac_pkg::*;

  //------------------------------------------------------------
  // run length

  localparam int CLK_PERIOD   = 40;    // adc_clk period in ns
  localparam int RST_CYCLES   = 16;    // reset held low
  localparam int RAND_CYCLES  = 2000;  // random bus and DAC traffic
  localparam int SWEEP_CYCLES = 33;    // 11 regions x 3 offsets
  localparam int TAIL_CYCLES  = 2;     // let the last compare run
  localparam int TOTAL_CYCLES = RST_CYCLES + RAND_CYCLES + SWEEP_CYCLES + TAIL_CYCLES;

  logic         adc_clk = 1'b0;
  logic         rst_n_i;
  sysbus_req_t  sys_req;      // master request
  sysbus_resp_t sys_resp;     // merged response
  used_mask_t   region_wen;   // gated write strobes
  used_mask_t   region_ren;   // gated read strobes
  region_resp_t region_resp;  // external block answers
  dac_pair_t    asg;          // generator samples
  dac_pair_t    pid;          // controller samples
  dac_pair_t    dac;          // mixer output

  logic [31:0]  rng_state = 32'he600e868;

  // inputs as seen before the last rising edge
  logic         prev_rst;
  dac_pair_t    prev_asg;
  dac_pair_t    prev_pid;

  rp_fabric_top DUT (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .sys_req_i     (sys_req),
    .sys_resp_o    (sys_resp),
    .region_wen_o  (region_wen),
    .region_ren_o  (region_ren),
    .region_resp_i (region_resp),
    .asg_i         (asg),
    .pid_i         (pid),
    .dac_o         (dac)
  );

  initial begin
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  //------------------------------------------------------------
  // random numbers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // mostly regions 0..7, then config block, then out-of-range indices
  function automatic logic [31:0] rand_addr();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [9:0]  idx;
    logic [19:0] ofs;
    r1 = next_rand();
    r2 = next_rand();
    if (!r1[3]) idx = {7'd0, r1[2:0]};          // used and free regions
    else if (!r1[2]) idx = 10'h3ff;             // config block
    else idx = 10'd8 + 10'(r1[31:8] % 1015);    // 8 .. 0x3fe
    case (r1[5:4])
      2'd0:    ofs = 20'hf0000;  // id word
      2'd1:    ofs = 20'hf0004;  // count word
      default: ofs = r2[19:0];
    endcase
    return {r2[31:30], idx, ofs};
  endfunction

  // {asg, pid} for one channel, with forced overflow corners
  function automatic logic [27:0] dac_stim(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return {2'b01, r[14:3], 2'b01, r[26:15]};  // both large positive
      3'd1:    return {2'b10, r[14:3], 2'b10, r[26:15]};  // both large negative
      3'd2:    return {14'h1fff, 14'h1fff};               // top corner
      3'd3:    return {14'h2000, 14'h2000};               // bottom corner
      default: return {r[16:3], r[30:17]};
    endcase
  endfunction

  function automatic logic [9:0] sweep_region(input int i);
    if (i < 8) return 10'(i);
    else if (i == 8) return 10'd8;  // first unmapped index
    else if (i == 9) return 10'h3fe;  // last unmapped index
    else return 10'h3ff;
  endfunction

  function automatic logic [19:0] sweep_offset(input int j);
    case (j)
      0:       return 20'hf0000;
      1:       return 20'hf0004;
      default: return 20'h00010;  // no word here
    endcase
  endfunction

  //------------------------------------------------------------
  // reference models

  function automatic used_mask_t ref_decode(input logic [31:0] addr, input logic strobe);
    used_mask_t m;
    int         idx;
    m   = '0;
    idx = int'(addr[29:20]);
    if (strobe && idx < 6) m[idx] = 1'b1;  // only external blocks get strobes
    return m;
  endfunction

  function automatic sysbus_resp_t ref_resp(input sysbus_req_t req, input region_resp_t resp);
    sysbus_resp_t r;
    int           idx;
    idx = int'(req.addr[29:20]);
    r   = '{rdata: 32'h0, err: 1'b0, ack: 1'b0};  // unmapped default
    if (idx < 6) begin
      r = resp[idx];
    end else if (idx < 8) begin
      r.ack = 1'b1;  // free region, idle answer
    end else if (idx == 'h3ff) begin
      r.ack = 1'b1;
      if (req.addr[19:0] == 20'hf0000) r.rdata = 32'hfff00001;
      else if (req.addr[19:0] == 20'hf0004) r.rdata = 32'd8;
    end
    return r;
  endfunction

  function automatic dac_sample_t saturate14(input int s);
    if (s > 8191) return 14'h1fff;
    else if (s < -8192) return 14'h2000;
    else return 14'(s);
  endfunction

  function automatic dac_pair_t ref_dac(input dac_pair_t a, input dac_pair_t p);
    dac_pair_t r;
    r.a = saturate14(int'($signed(a.a)) + int'($signed(p.a)));
    r.b = saturate14(int'($signed(a.b)) + int'($signed(p.b)));
    return r;
  endfunction

  //------------------------------------------------------------
  // compare tasks

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_strobes(input used_mask_t got, input used_mask_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input sysbus_resp_t got, input sysbus_resp_t exp);
    if (got.rdata !== exp.rdata) begin
      $display("FAIL %0t ns: rdata is %h, expected %h (addr %h)",
               $time, got.rdata, exp.rdata, sys_req.addr);
      abort_run();
    end
    if (got.ack !== exp.ack || got.err !== exp.err) begin
      $display("FAIL %0t ns: ack/err is %b/%b, expected %b/%b (addr %h)",
               $time, got.ack, got.err, exp.ack, exp.err, sys_req.addr);
      abort_run();
    end
  endtask

  task automatic check_dac(input dac_pair_t got, input dac_pair_t exp);
    if (got.a !== exp.a) begin
      $display("FAIL %0t ns: dac_o.a is %h, expected %h", $time, got.a, exp.a);
      abort_run();
    end
    if (got.b !== exp.b) begin
      $display("FAIL %0t ns: dac_o.b is %h, expected %h", $time, got.b, exp.b);
      abort_run();
    end
  endtask

  //------------------------------------------------------------
  // stimulus, new values after each rising edge

  task automatic drive_cycle(input logic [31:0] addr);
    sysbus_req_t  req;
    region_resp_t resp;
    logic [31:0]  r;
    logic [27:0]  ch_a;
    logic [27:0]  ch_b;
    r         = next_rand();
    req.addr  = addr;
    req.wdata = next_rand();
    req.sel   = r[3:0];
    req.wen   = r[4];
    req.ren   = r[5];
    for (int i = 0; i < USED_REGIONS; i++) begin
      r             = next_rand();
      resp[i].rdata = next_rand();  // noise on every entry
      resp[i].err   = r[0];
      resp[i].ack   = r[1];
    end
    ch_a = dac_stim(next_rand());
    ch_b = dac_stim(next_rand());
    @(posedge adc_clk);
    sys_req     <= req;
    region_resp <= resp;
    asg         <= '{a: ch_a[27:14], b: ch_b[27:14]};
    pid         <= '{a: ch_a[13:0], b: ch_b[13:0]};
  endtask

  initial begin
    rst_n_i     = 1'b0;
    sys_req     = '0;
    region_resp = '0;
    asg         = '0;
    pid         = '0;
    repeat (RST_CYCLES) drive_cycle(rand_addr());  // bus is live during reset
    rst_n_i <= 1'b1;
    repeat (RAND_CYCLES) drive_cycle(rand_addr());
    for (int i = 0; i < 11; i++) begin
      for (int j = 0; j < 3; j++) begin
        drive_cycle({2'b00, sweep_region(i), sweep_offset(j)});
      end
    end
    repeat (TAIL_CYCLES) @(posedge adc_clk);
    $display("Test passed");
    $finish;
  end

  //------------------------------------------------------------
  // compare on the falling edge, all values settled

  initial begin
    prev_rst = 1'b0;  // reset is low from time zero
    prev_asg = '0;
    prev_pid = '0;
    forever begin
      @(negedge adc_clk);
      check_strobes(region_wen, ref_decode(sys_req.addr, sys_req.wen), "region_wen_o");
      check_strobes(region_ren, ref_decode(sys_req.addr, sys_req.ren), "region_ren_o");
      check_resp(sys_resp, ref_resp(sys_req, region_resp));
      check_dac(dac, prev_rst ? ref_dac(prev_asg, prev_pid) : dac_pair_t'('0));
      prev_rst = rst_n_i;
      prev_asg = asg;
      prev_pid = pid;
    end
  end

  // watchdog, twice the planned run time
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("timeout: the run did not finish within %0d clock cycles", TOTAL_CYCLES * 2);
    abort_run();
  end

endmodule

//--- rp_fabric_top.f
verilog/sysbus_pkg.sv
verilog/dac_pkg.sv
verilog/sysbus_region_decode.sv
verilog/sysbus_read_mux.sv
verilog/dac_sat_sum.sv
verilog/rp_fabric_top.sv
verification/rp_fabric_tb.sv

//--- Bender.yml
package:
  name: rp_fabric
  description: "system bus glue and DAC mixer fabric"

sources:
  - verilog/sysbus_pkg.sv
  - verilog/dac_pkg.sv
  - verilog/sysbus_region_decode.sv
  - verilog/sysbus_read_mux.sv
  - verilog/dac_sat_sum.sv
  - verilog/rp_fabric_top.sv
  - target: test
    files:
      - verification/rp_fabric_tb.sv
